//--- pcs_rx_pkg.sv
// Receive PCS package with block, lane group and output word types and 64b/66b constants
package pcs_rx_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////

    localparam int BLOCK_W  = 64;
    localparam int ERRCNT_W = 8;

    ////////////////////////////////////////////////////////////////////
    // Sync headers and block type bytes
    ////////////////////////////////////////////////////////////////////

    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // Type byte sits in the first octet of a control block
    localparam logic [7:0] TYPE_IDLE  = 8'h1E;
    localparam logic [7:0] TYPE_START = 8'h78;
    localparam logic [7:0] TYPE_TERM  = 8'h87;

    ////////////////////////////////////////////////////////////////////
    // Block and lane types
    ////////////////////////////////////////////////////////////////////

    // One received 66-bit block
    typedef struct packed {
        logic [1:0]         hdr;
        logic [BLOCK_W-1:0] payload;
    } block_t;

    typedef enum logic [2:0] {
        DATA,
        START,
        TERM,
        IDLE,
        ERROR
    } blk_kind_t;

    // Block after classification
    typedef struct packed {
        blk_kind_t          kind;
        logic [BLOCK_W-1:0] payload;
        logic               in_frame;
    } class_lane_t;

    ////////////////////////////////////////////////////////////////////
    // Output word
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [BLOCK_W-1:0] data;
        logic               sop;
        logic               eop;
        logic               err;
    } rx_word_t;

endpackage

//--- block_descrambler.sv
// Descrambler stage, undoes x^58+x^39+1 over the lanes of a group in lane order
`timescale 1ns/1ps

module block_descrambler #(
    parameter int LANES = 4
) (
    input  logic                            clk_156,
    input  logic                            async_reset_n,
    input  pcs_rx_pkg::block_t [LANES-1:0]  group_i,
    input  logic                            valid_i,
    output logic                            ready_o,
    input  logic                            bypass_descram_i,
    output pcs_rx_pkg::block_t [LANES-1:0]  group_o,
    output logic                            valid_o,
    input  logic                            ready_i
);

    // Bit 0 holds the most recent received scrambled bit
    logic [57:0]                     hist_q;
    logic [57:0]                     hist_next;
    pcs_rx_pkg::block_t [LANES-1:0]  descr_group;
    pcs_rx_pkg::block_t [LANES-1:0]  group_q;
    logic                            valid_q;
    logic                            load;

    ////////////////////////////////////////////////////////////////////
    // Descrambler chain
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [57:0]                      hist;
        logic [pcs_rx_pkg::BLOCK_W-1:0]   descr;
        hist  = hist_q;
        descr = '0;
        for (int l = 0; l < LANES; l++) begin
            for (int b = 0; b < pcs_rx_pkg::BLOCK_W; b++) begin
                descr[b] = group_i[l].payload[b] ^ hist[38] ^ hist[57];
                hist     = {hist[56:0], group_i[l].payload[b]};
            end
            descr_group[l].hdr     = group_i[l].hdr;
            descr_group[l].payload = bypass_descram_i ? group_i[l].payload : descr;
        end
        // Last lane feeds lane 0 of the next group
        hist_next = hist;
    end

    ////////////////////////////////////////////////////////////////////
    // Elastic register
    ////////////////////////////////////////////////////////////////////

    assign ready_o = !valid_q || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_q <= 1'b0;
            hist_q  <= '0;
        end else begin
            if (load) begin
                valid_q <= 1'b1;
                hist_q  <= hist_next;
            end else if (ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (load) begin
            group_q <= descr_group;
        end
    end

    assign group_o = group_q;
    assign valid_o = valid_q;

endmodule

//--- block_classifier.sv
// Block classifier stage, decodes block kinds, chains frame state across lanes, counts errors
`timescale 1ns/1ps

module block_classifier #(
    parameter int LANES = 4
) (
    input  logic                                  clk_156,
    input  logic                                  async_reset_n,
    input  pcs_rx_pkg::block_t [LANES-1:0]        group_i,
    input  logic                                  valid_i,
    output logic                                  ready_o,
    input  logic                                  clear_errblk_i,
    output pcs_rx_pkg::class_lane_t [LANES-1:0]   group_o,
    output logic                                  valid_o,
    input  logic                                  ready_i,
    output logic [pcs_rx_pkg::ERRCNT_W-1:0]       errd_blks_o
);

    localparam int CNT_W = $clog2(LANES + 1);
    localparam int SUM_W = pcs_rx_pkg::ERRCNT_W + 1;

    pcs_rx_pkg::class_lane_t [LANES-1:0]  class_group;
    pcs_rx_pkg::class_lane_t [LANES-1:0]  group_q;
    logic                                 valid_q;
    logic                                 load;
    logic                                 frame_q;
    logic                                 frame_next;
    logic [CNT_W-1:0]                     n_err;
    logic [SUM_W-1:0]                     cnt_sum;
    logic [pcs_rx_pkg::ERRCNT_W-1:0]      errd_q;

    ////////////////////////////////////////////////////////////////////
    // Decode and frame chain
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        logic                   frame;
        pcs_rx_pkg::blk_kind_t  kind;
        frame = frame_q;
        n_err = '0;
        for (int l = 0; l < LANES; l++) begin
            // Raw kind from header and type byte
            if (group_i[l].hdr == pcs_rx_pkg::SYNC_DATA) begin
                kind = pcs_rx_pkg::DATA;
            end else if (group_i[l].hdr == pcs_rx_pkg::SYNC_CTRL) begin
                case (group_i[l].payload[7:0])
                    pcs_rx_pkg::TYPE_START: kind = pcs_rx_pkg::START;
                    pcs_rx_pkg::TYPE_TERM:  kind = pcs_rx_pkg::TERM;
                    pcs_rx_pkg::TYPE_IDLE:  kind = pcs_rx_pkg::IDLE;
                    default:                kind = pcs_rx_pkg::ERROR;
                endcase
            end else begin
                kind = pcs_rx_pkg::ERROR;
            end

            // Blocks that break the frame sequence
            if (!frame && (kind == pcs_rx_pkg::DATA || kind == pcs_rx_pkg::TERM)) begin
                kind = pcs_rx_pkg::ERROR;
            end else if (frame && kind == pcs_rx_pkg::START) begin
                kind = pcs_rx_pkg::ERROR;
            end

            class_group[l].kind     = kind;
            class_group[l].payload  = group_i[l].payload;
            class_group[l].in_frame = frame;

            if (kind == pcs_rx_pkg::START) begin
                frame = 1'b1;
            end else if (kind == pcs_rx_pkg::TERM || kind == pcs_rx_pkg::ERROR) begin
                frame = 1'b0;
            end

            if (kind == pcs_rx_pkg::ERROR) begin
                n_err = n_err + CNT_W'(1);
            end
        end
        frame_next = frame;
    end

    assign cnt_sum = {1'b0, errd_q} + SUM_W'(n_err);

    ////////////////////////////////////////////////////////////////////
    // Elastic register, frame state and error counter
    ////////////////////////////////////////////////////////////////////

    assign ready_o = !valid_q || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            valid_q <= 1'b0;
            frame_q <= 1'b0;
        end else begin
            if (load) begin
                valid_q <= 1'b1;
                frame_q <= frame_next;
            end else if (ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Saturates at all ones, clear wins over counting
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            errd_q <= '0;
        end else if (clear_errblk_i) begin
            errd_q <= '0;
        end else if (load) begin
            if (cnt_sum[SUM_W-1]) begin
                errd_q <= '1;
            end else begin
                errd_q <= cnt_sum[pcs_rx_pkg::ERRCNT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (load) begin
            group_q <= class_group;
        end
    end

    assign group_o     = group_q;
    assign valid_o     = valid_q;
    assign errd_blks_o = errd_q;

endmodule

//--- lane_serializer.sv
// Lane serializer, walks a classified group and emits one payload word per beat
`timescale 1ns/1ps

module lane_serializer #(
    parameter int LANES = 4
) (
    input  logic                                  clk_156,
    input  logic                                  async_reset_n,
    input  pcs_rx_pkg::class_lane_t [LANES-1:0]   group_i,
    input  logic                                  valid_i,
    output logic                                  ready_o,
    output pcs_rx_pkg::rx_word_t                  word_o,
    output logic                                  word_valid_o,
    input  logic                                  word_ready_i
);

    localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;

    pcs_rx_pkg::class_lane_t [LANES-1:0]  group_q;
    logic                                 hold_valid_q;
    logic [LANE_W-1:0]                    lane_q;
    pcs_rx_pkg::class_lane_t              cur;
    logic                                 is_data;
    logic                                 is_start;
    logic                                 err_in;
    logic                                 ends;
    logic                                 last_lane;
    logic                                 need_emit;
    logic                                 out_free;
    logic                                 step;
    logic                                 emit;
    logic                                 load;

    // Word held back until the next block decides its eop
    logic [pcs_rx_pkg::BLOCK_W-1:0]       pend_data_q;
    logic                                 pend_sop_q;
    logic                                 pend_valid_q;
    logic                                 first_q;
    pcs_rx_pkg::rx_word_t                 word_q;
    logic                                 word_valid_q;

    ////////////////////////////////////////////////////////////////////
    // Lane walk
    ////////////////////////////////////////////////////////////////////

    assign cur       = group_q[lane_q];
    assign is_data   = cur.kind == pcs_rx_pkg::DATA;
    assign is_start  = cur.kind == pcs_rx_pkg::START;
    assign err_in    = cur.kind == pcs_rx_pkg::ERROR && cur.in_frame;
    assign ends      = cur.kind == pcs_rx_pkg::TERM || err_in;
    assign last_lane = lane_q == LANE_W'(LANES - 1);

    assign out_free  = !word_valid_q || word_ready_i;
    assign need_emit = pend_valid_q && (is_data || ends);
    assign step      = hold_valid_q && (!need_emit || out_free);
    assign emit      = step && need_emit;

    assign ready_o   = !hold_valid_q || (step && last_lane);
    assign load      = valid_i && ready_o;

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            hold_valid_q <= 1'b0;
            lane_q       <= '0;
        end else begin
            if (load) begin
                hold_valid_q <= 1'b1;
                lane_q       <= '0;
            end else if (step) begin
                if (last_lane) begin
                    hold_valid_q <= 1'b0;
                    lane_q       <= '0;
                end else begin
                    lane_q <= lane_q + LANE_W'(1);
                end
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (load) begin
            group_q <= group_i;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Pending word and frame start tracking
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            pend_valid_q <= 1'b0;
            first_q      <= 1'b0;
        end else if (step) begin
            if (is_data) begin
                pend_valid_q <= 1'b1;
                first_q      <= 1'b0;
            end else if (ends) begin
                pend_valid_q <= 1'b0;
            end else if (is_start) begin
                first_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_156) begin
        if (step && is_data) begin
            pend_data_q <= cur.payload;
            pend_sop_q  <= first_q;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            word_valid_q <= 1'b0;
        end else if (emit) begin
            word_valid_q <= 1'b1;
        end else if (word_ready_i) begin
            word_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_156) begin
        if (emit) begin
            word_q.data <= pend_data_q;
            word_q.sop  <= pend_sop_q;
            word_q.eop  <= ends;
            word_q.err  <= err_in;
        end
    end

    assign word_o       = word_q;
    assign word_valid_o = word_valid_q;

endmodule

//--- pcs_rx_top.sv
// Receive PCS top, chains descrambler, classifier and serializer on clk_156
`timescale 1ns/1ps

module pcs_rx_top #(
    parameter int LANES = 4
) (
    input  logic                              clk_156,
    input  logic                              async_reset_n,
    input  pcs_rx_pkg::block_t [LANES-1:0]    rx_group_i,
    input  logic                              rx_valid_i,
    output logic                              rx_ready_o,
    input  logic                              bypass_descram_i,
    input  logic                              clear_errblk_i,
    output pcs_rx_pkg::rx_word_t              word_o,
    output logic                              word_valid_o,
    input  logic                              word_ready_i,
    output logic [pcs_rx_pkg::ERRCNT_W-1:0]   errd_blks_o
);

    pcs_rx_pkg::block_t [LANES-1:0]       desc_group;
    logic                                 desc_valid;
    logic                                 desc_ready;
    pcs_rx_pkg::class_lane_t [LANES-1:0]  class_group;
    logic                                 class_valid;
    logic                                 class_ready;

    block_descrambler #(
        .LANES (LANES)
    ) u_descrambler (
        .clk_156          (clk_156),
        .async_reset_n    (async_reset_n),
        .group_i          (rx_group_i),
        .valid_i          (rx_valid_i),
        .ready_o          (rx_ready_o),
        .bypass_descram_i (bypass_descram_i),
        .group_o          (desc_group),
        .valid_o          (desc_valid),
        .ready_i          (desc_ready)
    );

    block_classifier #(
        .LANES (LANES)
    ) u_classifier (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .group_i        (desc_group),
        .valid_i        (desc_valid),
        .ready_o        (desc_ready),
        .clear_errblk_i (clear_errblk_i),
        .group_o        (class_group),
        .valid_o        (class_valid),
        .ready_i        (class_ready),
        .errd_blks_o    (errd_blks_o)
    );

    lane_serializer #(
        .LANES (LANES)
    ) u_serializer (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .group_i       (class_group),
        .valid_i       (class_valid),
        .ready_o       (class_ready),
        .word_o        (word_o),
        .word_valid_o  (word_valid_o),
        .word_ready_i  (word_ready_i)
    );

endmodule

//--- tb_pcs_rx.sv
// Testbench for the receive PCS top, replays pattern file groups and checks words and error counts
`timescale 1ns/1ps

module tb_pcs_rx;

    localparam int LANES   = 4;
    localparam int MEM_LEN = 128;
    localparam int TIMEOUT = 2000;

    logic                                 clk_156;
    logic                                 async_reset_n;
    pcs_rx_pkg::block_t [LANES-1:0]       rx_group_i;
    logic                                 rx_valid_i;
    logic                                 rx_ready_o;
    logic                                 bypass_descram_i;
    logic                                 clear_errblk_i;
    pcs_rx_pkg::rx_word_t                 word_o;
    logic                                 word_valid_o;
    logic                                 word_ready_i;
    logic [pcs_rx_pkg::ERRCNT_W-1:0]      errd_blks_o;

    // Tag in bits 71:64, block, word or count in bits 63:0
    logic [71:0]                  pat_mem [MEM_LEN];
    pcs_rx_pkg::block_t           blk_q [$];
    pcs_rx_pkg::rx_word_t         exp_q [$];
    logic [57:0]                  scr_hist;
    logic [57:0]                  next_hist;
    logic [31:0]                  lcg_state;
    int                           rec;
    int                           checks;
    int                           errors;
    int                           tests;
    logic                         timed_out;

    pcs_rx_top #(
        .LANES (LANES)
    ) u_dut (
        .clk_156          (clk_156),
        .async_reset_n    (async_reset_n),
        .rx_group_i       (rx_group_i),
        .rx_valid_i       (rx_valid_i),
        .rx_ready_o       (rx_ready_o),
        .bypass_descram_i (bypass_descram_i),
        .clear_errblk_i   (clear_errblk_i),
        .word_o           (word_o),
        .word_valid_o     (word_valid_o),
        .word_ready_i     (word_ready_i),
        .errd_blks_o      (errd_blks_o)
    );

    always #10 clk_156 = ~clk_156;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Scrambler x^58+x^39+1, history shifts in the sent bit
    task automatic build_group(input int base);
        pcs_rx_pkg::block_t [LANES-1:0]  grp;
        logic [57:0]                     h;
        logic                            s;
        h = scr_hist;
        for (int l = 0; l < LANES; l++) begin
            grp[l].hdr = blk_q[base + l].hdr;
            for (int b = 0; b < pcs_rx_pkg::BLOCK_W; b++) begin
                s = blk_q[base + l].payload[b];
                if (!bypass_descram_i) begin
                    s = s ^ h[38] ^ h[57];
                end
                grp[l].payload[b] = s;
                h = {h[56:0], s};
            end
        end
        rx_group_i = grp;
        next_hist  = h;
    endtask

    task automatic compare_word();
        pcs_rx_pkg::rx_word_t exp_word;
        if (exp_q.size() == 0) begin
            $display("Unexpected output word %h while no word was expected", word_o.data);
            errors++;
        end else begin
            exp_word = exp_q.pop_front();
            check_value("word_o.data", word_o.data, exp_word.data);
            check_value("word_o.sop", 64'(word_o.sop), 64'(exp_word.sop));
            check_value("word_o.eop", 64'(word_o.eop), 64'(exp_word.eop));
            check_value("word_o.err", 64'(word_o.err), 64'(exp_word.err));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One test from the pattern file
    //////////////////////////////////////////////////////////////////////

    task automatic run_test();
        logic [3:0]            mode;
        logic [7:0]            exp_cnt;
        int                    groups;
        int                    sent;
        int                    cycles;
        int                    stall;
        int                    errs_at_start;
        logic                  pend;
        logic                  saw_block;
        pcs_rx_pkg::block_t    blk;
        pcs_rx_pkg::rx_word_t  word;
        mode          = pat_mem[rec][67:64];
        exp_cnt       = pat_mem[rec][7:0];
        errs_at_start = errors;
        rec++;
        while (pat_mem[rec][71:68] == 4'h1 || pat_mem[rec][71:68] == 4'h2) begin
            if (pat_mem[rec][71:68] == 4'h1) begin
                blk.hdr     = pat_mem[rec][65:64];
                blk.payload = pat_mem[rec][63:0];
                blk_q.push_back(blk);
            end else begin
                word.data = pat_mem[rec][63:0];
                word.sop  = pat_mem[rec][66];
                word.eop  = pat_mem[rec][65];
                word.err  = pat_mem[rec][64];
                exp_q.push_back(word);
            end
            rec++;
        end
        groups    = blk_q.size() / LANES;
        sent      = 0;
        cycles    = 0;
        stall     = mode[2] ? 50 : 0;
        pend      = 1'b0;
        saw_block = 1'b0;

        @(negedge clk_156);
        bypass_descram_i = mode[0];
        clear_errblk_i   = mode[1];
        @(negedge clk_156);
        clear_errblk_i   = 1'b0;

        while ((sent < groups || exp_q.size() > 0) && !timed_out) begin
            @(negedge clk_156);
            if (!pend) begin
                rx_valid_i = sent < groups;
                if (sent < groups) begin
                    build_group(sent * LANES);
                    pend = 1'b1;
                end
            end
            if (stall > 0) begin
                word_ready_i = 1'b0;
                stall--;
            end else begin
                lcg_state    = lcg_next(lcg_state);
                word_ready_i = lcg_state[31:30] != 2'b00;
            end
            // Handshakes seen here complete on the next rising edge
            #1;
            if (word_valid_o && word_ready_i) begin
                compare_word();
            end
            if (rx_valid_i && rx_ready_o) begin
                scr_hist = next_hist;
                sent++;
                pend = 1'b0;
            end else if (rx_valid_i && stall > 0) begin
                saw_block = 1'b1;
            end
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("Timeout, %0d of %0d groups sent and %0d words still expected",
                         sent, groups, exp_q.size());
                errors++;
                timed_out = 1'b1;
            end
        end

        // Pipeline drains, nothing may be left over
        for (int i = 0; i < 8; i++) begin
            @(negedge clk_156);
            rx_valid_i   = 1'b0;
            word_ready_i = 1'b1;
            #1;
            if (word_valid_o) begin
                $display("Extra output word %h after the last expected word", word_o.data);
                errors++;
            end
        end
        blk_q.delete();
        exp_q.delete();
        if (mode[2]) begin
            check_value("rx_ready_o low during stall", 64'(saw_block), 64'd1);
        end
        check_value("errd_blks_o", 64'(errd_blks_o), 64'(exp_cnt));
        tests++;
        $display("Test %0d finished, %0d errors", tests, errors - errs_at_start);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk_156          = 1'b0;
        async_reset_n    = 1'b0;
        rx_group_i       = '0;
        rx_valid_i       = 1'b0;
        bypass_descram_i = 1'b0;
        clear_errblk_i   = 1'b0;
        word_ready_i     = 1'b0;
        scr_hist         = '0;
        next_hist        = '0;
        lcg_state        = 32'he6bf_7eb9;
        rec              = 0;
        checks           = 0;
        errors           = 0;
        tests            = 0;
        timed_out        = 1'b0;
        $readmemh("rx_patterns.hex", pat_mem);

        repeat (10) @(posedge clk_156);
        @(negedge clk_156);
        async_reset_n = 1'b1;
        @(negedge clk_156);
        #1;
        check_value("word_valid_o", 64'(word_valid_o), 64'd0);
        check_value("errd_blks_o", 64'(errd_blks_o), 64'd0);
        tests++;
        $display("Test %0d finished, %0d errors", tests, errors);

        while (pat_mem[rec][71:68] == 4'h3 && !timed_out) begin
            run_test();
        end

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- rx_patterns.hex
// Tag 1H is a block with sync header H, 2F an expected word with F = {sop,eop,err}
// Tag 3M starts a test, M = {stall,clear,bypass}, value is the expected errd_blks_o
// Scrambled frames across groups
300000000000000000
120000000000000078 110123456789ABCDEF 120000000000000087 120000000000000078
11FEDCBA9876543210 120000000000000087 120000000000000078 11A5A5A5A55A5A5A5A
110000000000000001 118000000000000000 1113579BDF2468ACE0 11FFFFFFFFFFFFFFFF
120000000000000087 12000000000000001E 12000000000000001E 12000000000000001E
260123456789ABCDEF 26FEDCBA9876543210 24A5A5A5A55A5A5A5A 200000000000000001
208000000000000000 2013579BDF2468ACE0 22FFFFFFFFFFFFFFFF
// Descrambler bypass
310000000000000000
120000000000000078 111122334455667788 1199AABBCCDDEEFF00 120000000000000087
12000000000000001E 120000000000000078 110F0F0F0F0F0F0F0F 120000000000000087
241122334455667788 2299AABBCCDDEEFF00 260F0F0F0F0F0F0F0F
// Error blocks, frame cut by a bad header
300000000000000005
117777777777777777 100000000000000000 120000000000000055 120000000000000087
120000000000000078 113C3C3C3C3C3C3C3C 11C3C3C3C3C3C3C3C3 130000000000000000
12000000000000001E 12000000000000001E 12000000000000001E 12000000000000001E
243C3C3C3C3C3C3C3C 23C3C3C3C3C3C3C3C3
// Counter clear
320000000000000000
// Output stall
340000000000000000
120000000000000078 110000000100000002 110000000300000004 110000000500000006
110000000700000008 120000000000000087 120000000000000078 11000000090000000A
120000000000000087 12000000000000001E 12000000000000001E 12000000000000001E
120000000000000078 110000000B0000000C 120000000000000087 12000000000000001E
240000000100000002 200000000300000004 200000000500000006 220000000700000008
26000000090000000A 260000000B0000000C
FF0000000000000000

//--- files.f
pcs_rx_pkg.sv
block_descrambler.sv
block_classifier.sv
lane_serializer.sv
pcs_rx_top.sv
tb_pcs_rx.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the receive PCS testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_pcs_rx -f files.f &&
sim_out="$(./obj_dir/Vtb_pcs_rx)" &&
echo "$sim_out" &&
echo "$sim_out" | grep -qx "Simulation passed" || {
    echo "Run did not pass"
    exit 1
}
